/* include/ddr_if_cfg.svh */
// ######################################
// Sizes for the DDR request front end
// Word must be exactly two app beats
// ######################################

`ifndef DDR_IF_CFG_SVH
`define DDR_IF_CFG_SVH

// Request and app address width
`define DDR_ADDR_W 27

// Request word and app beat widths
`define DDR_DATA_W 128
`define DDR_BEAT_W 64   // Two beats per word

// Queue depths, each at least 2
`define DDR_WR_DEPTH  8
`define DDR_RD_DEPTH  8
`define DDR_RET_DEPTH 8 // Also the cap on outstanding reads

`endif

/* design/ddr_if_pkg.sv */
// ######################################
// Shared types for the DDR front end
// Widths come from ddr_if_cfg.svh
// ######################################

`include "ddr_if_cfg.svh"

package ddr_if_pkg;

    // Request address, also used as app_addr
    typedef logic [`DDR_ADDR_W-1:0] addr_t;

    // Full request word
    typedef logic [`DDR_DATA_W-1:0] data_t;

    // One app data beat
    typedef logic [`DDR_BEAT_W-1:0] beat_t;

    // Controller command encoding
    typedef enum logic [2:0] {
        CMD_WRITE = 3'd0,
        CMD_READ  = 3'd1
    } app_cmd_t;

    // Write queue entry
    typedef struct packed {
        addr_t addr;
        data_t data;
    } wr_entry_t;

    // Return buffer entry, address paired with assembled word
    typedef struct packed {
        addr_t addr;
        data_t data;
    } ret_entry_t;

endpackage

/* design/sync_fifo.sv */
// ######################################
// Single clock FIFO, fall-through head
// DEPTH must be 2 or more
// ######################################

`timescale 1ns/1ps

module sync_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,      // Ignored when full
    input  entry_t                     push_data,
    input  logic                       pop,       // Ignored when empty
    output entry_t                     head,      // Valid while not_empty
    output logic                       not_empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] count     // Current occupancy
);

    localparam int PW = $clog2(DEPTH);

    entry_t        mem [DEPTH]; // Storage, no reset needed
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;

    // Pointer advance with wrap at DEPTH-1
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        next_ptr = (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign not_empty = (count != '0);
    assign full      = (count == DEPTH);
    assign head      = mem[rd_ptr]; // Shown without delay

    // Entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

endmodule

/* design/ddr_fifo.sv */
// ######################################
// Request queues and read return buffer
// Read data cannot stall, so reads are
// capped at DDR_RET_DEPTH outstanding
// ######################################

`timescale 1ns/1ps
`include "ddr_if_cfg.svh"

module ddr_fifo (
    input  logic              clk,
    input  logic              rst_n,

    // Requester
    input  ddr_if_pkg::addr_t wr_adx_in,
    input  ddr_if_pkg::data_t wr_data_in,
    input  logic              write_req,       // Taken when write_allowed
    output logic              write_allowed,
    output logic              writes_pending,
    input  ddr_if_pkg::addr_t rd_adx_in,
    input  logic              read_req,        // Taken when read_allowed
    output logic              read_allowed,
    output logic              reads_pending,

    // Dispatcher
    output ddr_if_pkg::addr_t wr_adx_out,
    output ddr_if_pkg::data_t wr_data_out,
    output logic              has_wr,
    input  logic              get_wr,          // Pop write head
    output ddr_if_pkg::addr_t rd_adx_out,
    output logic              has_rd,
    input  logic              get_rd,          // Pop read head, goes in flight
    input  logic              write_busy,      // Dispatcher still sending a write

    // App read return
    input  ddr_if_pkg::beat_t app_rd_data,
    input  logic              app_rd_data_valid,

    // Consumer
    output ddr_if_pkg::data_t return_data,
    output ddr_if_pkg::addr_t return_adx,
    output logic              has_return_data,
    input  logic              get_return_data
);

    ddr_if_pkg::wr_entry_t  wq_in;
    ddr_if_pkg::wr_entry_t  wq_head;
    logic                   wq_full;
    logic                   rq_full;
    ddr_if_pkg::addr_t      if_head;     // Oldest in-flight address
    logic                   if_not_empty;
    ddr_if_pkg::ret_entry_t ret_in;
    ddr_if_pkg::ret_entry_t ret_head;
    logic                   rd_accept;
    logic                   ret_pop;
    logic                   beat_hi;     // Next beat is the high half
    logic                   second_beat;
    ddr_if_pkg::beat_t      low_beat_q;  // Held low half of a read word
    logic [$clog2(`DDR_RET_DEPTH+1)-1:0] rd_outstanding;

    assign rd_accept   = read_req && read_allowed;
    assign ret_pop     = get_return_data && has_return_data;
    assign second_beat = app_rd_data_valid && beat_hi;

    // Write requests
    assign wq_in         = '{addr: wr_adx_in, data: wr_data_in};
    assign write_allowed = !wq_full;
    assign wr_adx_out    = wq_head.addr;
    assign wr_data_out   = wq_head.data;
    assign writes_pending = has_wr || write_busy;

    sync_fifo #(
        .entry_t (ddr_if_pkg::wr_entry_t),
        .DEPTH   (`DDR_WR_DEPTH)
    ) wr_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (write_req && write_allowed),
        .push_data (wq_in),
        .pop       (get_wr),
        .head      (wq_head),
        .not_empty (has_wr),
        .full      (wq_full),
        .count     ()
    );

    // Read requests waiting for dispatch
    sync_fifo #(
        .entry_t (ddr_if_pkg::addr_t),
        .DEPTH   (`DDR_RD_DEPTH)
    ) rd_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rd_accept),
        .push_data (rd_adx_in),
        .pop       (get_rd),
        .head      (rd_adx_out),
        .not_empty (has_rd),
        .full      (rq_full),
        .count     ()
    );

    // Addresses of issued reads, in command order
    sync_fifo #(
        .entry_t (ddr_if_pkg::addr_t),
        .DEPTH   (`DDR_RET_DEPTH)
    ) inflight_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (get_rd),          // Same cycle as the read pop
        .push_data (rd_adx_out),
        .pop       (second_beat),
        .head      (if_head),
        .not_empty (if_not_empty),
        .full      (),                // Bounded by rd_outstanding
        .count     ()
    );

    assign reads_pending = has_rd || if_not_empty;

    // Low beat first, then high beat completes the word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_hi <= 1'b0;
        end else if (app_rd_data_valid) begin
            beat_hi <= !beat_hi;
        end
    end

    always_ff @(posedge clk) begin
        if (app_rd_data_valid && !beat_hi) begin
            low_beat_q <= app_rd_data;
        end
    end

    assign ret_in = '{addr: if_head, data: {app_rd_data, low_beat_q}};

    // Completed words waiting for the consumer
    sync_fifo #(
        .entry_t (ddr_if_pkg::ret_entry_t),
        .DEPTH   (`DDR_RET_DEPTH)
    ) ret_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (second_beat),
        .push_data (ret_in),
        .pop       (get_return_data), // Empty pop ignored inside
        .head      (ret_head),
        .not_empty (has_return_data),
        .full      (),                // Never reached, see read_allowed
        .count     ()
    );

    assign return_data = ret_head.data;
    assign return_adx  = ret_head.addr;

    // Reads from acceptance until the consumer pops them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_outstanding <= '0;
        end else begin
            case ({rd_accept, ret_pop})
                2'b10:   rd_outstanding <= rd_outstanding + 1'b1;
                2'b01:   rd_outstanding <= rd_outstanding - 1'b1;
                default: rd_outstanding <= rd_outstanding;
            endcase
        end
    end

    assign read_allowed = !rq_full && (rd_outstanding < `DDR_RET_DEPTH);

endmodule

/* design/fifo_to_app.sv */
// ######################################
// Queue to app interface dispatcher
// Writes and reads alternate when both
// wait, write first after reset
// ######################################

`timescale 1ns/1ps
`include "ddr_if_cfg.svh"

module fifo_to_app (
    input  logic                 clk,
    input  logic                 rst_n,

    // Queue side
    input  logic                 has_wr,
    input  ddr_if_pkg::addr_t    wr_adx_in,
    input  ddr_if_pkg::data_t    wr_data_in,
    output logic                 get_wr,      // Pulse on write command accept
    input  logic                 has_rd,
    input  ddr_if_pkg::addr_t    rd_adx_in,
    output logic                 get_rd,      // Pulse on read command accept
    output logic                 write_busy,

    // Controller app interface
    output ddr_if_pkg::addr_t    app_addr,
    output ddr_if_pkg::app_cmd_t app_cmd,
    output logic                 app_en,
    input  logic                 app_rdy,
    output ddr_if_pkg::beat_t    app_wdf_data,
    output logic                 app_wdf_wren,
    output logic                 app_wdf_end,
    input  logic                 app_wdf_rdy
);

    typedef enum logic [1:0] {
        ST_IDLE,  // Waiting for a request
        ST_CMD,   // app_en held until app_rdy
        ST_LOW,   // Low write beat
        ST_HIGH   // High write beat, app_wdf_end
    } state_t;

    state_t               state;
    logic                 last_wr;    // Last grant went to a write
    logic                 pick_wr;
    logic                 pick_rd;
    logic                 cmd_done;
    logic                 beat_done;
    ddr_if_pkg::app_cmd_t cmd_q;
    ddr_if_pkg::addr_t    addr_q;
    ddr_if_pkg::data_t    data_q;     // Word kept after the queue pops

    // Alternate only when both sides wait
    assign pick_wr = has_wr && (!has_rd || !last_wr);
    assign pick_rd = has_rd && !pick_wr;

    assign cmd_done  = (state == ST_CMD) && app_rdy;
    assign beat_done = app_wdf_wren && app_wdf_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            last_wr <= 1'b0;
            cmd_q   <= ddr_if_pkg::CMD_WRITE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pick_wr || pick_rd) begin
                        state   <= ST_CMD;
                        last_wr <= pick_wr;
                        cmd_q   <= pick_wr ? ddr_if_pkg::CMD_WRITE : ddr_if_pkg::CMD_READ;
                    end
                end
                ST_CMD: begin
                    if (cmd_done) begin // Reads finish here
                        state <= (cmd_q == ddr_if_pkg::CMD_WRITE) ? ST_LOW : ST_IDLE;
                    end
                end
                ST_LOW: begin
                    if (beat_done) begin
                        state <= ST_HIGH;
                    end
                end
                ST_HIGH: begin
                    if (beat_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address and word captured at grant
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && (pick_wr || pick_rd)) begin
            addr_q <= pick_wr ? wr_adx_in : rd_adx_in;
            data_q <= wr_data_in;
        end
    end

    // Queue pops follow command acceptance
    assign get_wr = cmd_done && (cmd_q == ddr_if_pkg::CMD_WRITE);
    assign get_rd = cmd_done && (cmd_q == ddr_if_pkg::CMD_READ);

    assign write_busy = (state == ST_LOW) || (state == ST_HIGH)
                     || ((state == ST_CMD) && (cmd_q == ddr_if_pkg::CMD_WRITE));

    // App outputs come straight from state and captured payload
    assign app_en       = (state == ST_CMD);
    assign app_cmd      = cmd_q;
    assign app_addr     = addr_q;
    assign app_wdf_wren = (state == ST_LOW) || (state == ST_HIGH);
    assign app_wdf_end  = (state == ST_HIGH);
    assign app_wdf_data = (state == ST_HIGH) ? data_q[2*`DDR_BEAT_W-1:`DDR_BEAT_W]
                                             : data_q[`DDR_BEAT_W-1:0];

endmodule

/* design/ddr_memory_interface.sv */
// ######################################
// Front end top, one clock domain
// DDR controller sits outside on app_*
// app_rd_data_end is not used
// ######################################

`timescale 1ns/1ps

module ddr_memory_interface (
    input  logic                 clk,
    input  logic                 rst_n,

    // Requester
    input  ddr_if_pkg::addr_t    wr_adx_in,
    input  ddr_if_pkg::data_t    wr_data_in,
    input  logic                 write_req,
    output logic                 write_allowed,
    output logic                 writes_pending,
    input  ddr_if_pkg::addr_t    rd_adx_in,
    input  logic                 read_req,
    output logic                 read_allowed,
    output logic                 reads_pending,

    // Consumer
    output ddr_if_pkg::data_t    rd_data_return,
    output ddr_if_pkg::addr_t    rd_adx_return,
    output logic                 has_return_data,
    input  logic                 get_return_data,

    // Controller app interface
    output ddr_if_pkg::addr_t    app_addr,
    output ddr_if_pkg::app_cmd_t app_cmd,
    output logic                 app_en,
    input  logic                 app_rdy,
    output ddr_if_pkg::beat_t    app_wdf_data,
    output logic                 app_wdf_wren,
    output logic                 app_wdf_end,
    input  logic                 app_wdf_rdy,
    input  ddr_if_pkg::beat_t    app_rd_data,
    input  logic                 app_rd_data_valid,
    input  logic                 app_rd_data_end   // Beat count kept internally
);

    ddr_if_pkg::addr_t disp_wr_adx;
    ddr_if_pkg::data_t disp_wr_data;
    logic              disp_has_wr;
    logic              disp_get_wr;
    ddr_if_pkg::addr_t disp_rd_adx;
    logic              disp_has_rd;
    logic              disp_get_rd;
    logic              disp_write_busy;

    // Queues and return buffer
    ddr_fifo req_receiving (
        .clk, .rst_n,
        .wr_adx_in, .wr_data_in, .write_req, .write_allowed, .writes_pending,
        .rd_adx_in, .read_req, .read_allowed, .reads_pending,
        .wr_adx_out        (disp_wr_adx),
        .wr_data_out       (disp_wr_data),
        .has_wr            (disp_has_wr),
        .get_wr            (disp_get_wr),
        .rd_adx_out        (disp_rd_adx),
        .has_rd            (disp_has_rd),
        .get_rd            (disp_get_rd),
        .write_busy        (disp_write_busy),
        .app_rd_data, .app_rd_data_valid,
        .return_data       (rd_data_return),
        .return_adx        (rd_adx_return),
        .has_return_data, .get_return_data
    );

    // Commands and write beats to the controller
    fifo_to_app req_dispatch (
        .clk, .rst_n,
        .has_wr            (disp_has_wr),
        .wr_adx_in         (disp_wr_adx),
        .wr_data_in        (disp_wr_data),
        .get_wr            (disp_get_wr),
        .has_rd            (disp_has_rd),
        .rd_adx_in         (disp_rd_adx),
        .get_rd            (disp_get_rd),
        .write_busy        (disp_write_busy),
        .app_addr, .app_cmd, .app_en, .app_rdy,
        .app_wdf_data, .app_wdf_wren, .app_wdf_end, .app_wdf_rdy
    );

endmodule

/* testbench/tb_clock_gen.sv */
// ######################################
// 20 ns clock, reset low for 5 cycles
// ######################################

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);         // Released away from the active edge
        rst_n = 1'b1;
    end

endmodule

/* testbench/app_mem_model.sv */
// ######################################
// Controller user side model, no timing
// Reads return in order, unwritten = 0
// ######################################

`timescale 1ns/1ps

module app_mem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 hold_off,          // Forces app_rdy low
    input  ddr_if_pkg::addr_t    app_addr,
    input  ddr_if_pkg::app_cmd_t app_cmd,
    input  logic                 app_en,
    output logic                 app_rdy,
    input  ddr_if_pkg::beat_t    app_wdf_data,
    input  logic                 app_wdf_wren,
    input  logic                 app_wdf_end,
    output logic                 app_wdf_rdy,
    output ddr_if_pkg::beat_t    app_rd_data,
    output logic                 app_rd_data_valid,
    output logic                 app_rd_data_end
);

    integer            seed = 32'h816eb43d;
    logic [31:0]       rnd;
    logic              rdy_rand;
    logic              rd_hi;                      // High beat due next
    longint            cycle;
    ddr_if_pkg::beat_t low_beat;                   // Low write beat held
    ddr_if_pkg::data_t rd_word;
    ddr_if_pkg::data_t mem [ddr_if_pkg::addr_t];   // Backing store
    ddr_if_pkg::addr_t wr_addr_q [$];              // Write cmds awaiting data
    ddr_if_pkg::addr_t rd_addr_q [$];              // Read cmds in order
    longint            rd_due_q [$];               // Cycle each read may return

    assign app_rdy = rdy_rand && !hold_off;

    // Commands and write beats taken at the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (app_en && app_rdy) begin
                if (app_cmd == ddr_if_pkg::CMD_WRITE) begin
                    wr_addr_q.push_back(app_addr);
                end else begin
                    rd_addr_q.push_back(app_addr);
                    rd_due_q.push_back(cycle + 2 + rnd[5:4]); // Few cycles latency
                end
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                if (!app_wdf_end) begin
                    low_beat = app_wdf_data;
                end else begin
                    mem[wr_addr_q.pop_front()] = {app_wdf_data, low_beat};
                end
            end
        end
    end

    // Ready stalls and read beats change on the falling edge
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_rand          <= 1'b0;
            app_wdf_rdy       <= 1'b0;
            app_rd_data       <= '0;
            app_rd_data_valid <= 1'b0;
            app_rd_data_end   <= 1'b0;
            rd_hi             <= 1'b0;
        end else begin
            rnd = $random(seed);
            rdy_rand          <= (rnd[1:0] != 2'b00);  // Stall about 1 in 4
            app_wdf_rdy       <= (rnd[3:2] != 2'b00);
            app_rd_data_valid <= 1'b0;
            app_rd_data_end   <= 1'b0;
            if (rd_hi) begin
                app_rd_data       <= rd_word[127:64];
                app_rd_data_valid <= 1'b1;
                app_rd_data_end   <= 1'b1;
                rd_hi             <= 1'b0;
            end else if (rd_addr_q.size() != 0 && cycle >= rd_due_q[0]) begin
                rd_word = mem.exists(rd_addr_q[0]) ? mem[rd_addr_q[0]] : '0;
                void'(rd_addr_q.pop_front());
                void'(rd_due_q.pop_front());
                app_rd_data       <= rd_word[63:0];    // Low beat first
                app_rd_data_valid <= 1'b1;
                rd_hi             <= 1'b1;
            end
        end
    end

endmodule

/* testbench/ddr_memory_interface_asserts.sv */
// ######################################
// App handshake and flag properties
// Bound into ddr_memory_interface
// ######################################

`timescale 1ns/1ps

module ddr_memory_interface_asserts (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 app_en,
    input logic                 app_rdy,
    input ddr_if_pkg::addr_t    app_addr,
    input ddr_if_pkg::app_cmd_t app_cmd,
    input logic                 app_wdf_wren,
    input logic                 app_wdf_rdy,
    input ddr_if_pkg::beat_t    app_wdf_data,
    input logic                 app_wdf_end,
    input logic                 write_allowed,
    input logic                 read_allowed
);

    int fail_count = 0; // Failed assertions so far

    // Command held until accepted
    a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (app_en && !app_rdy) |=> (app_en && $stable(app_addr) && $stable(app_cmd)))
        else begin
            $error("app command changed before app_rdy");
            fail_count++;
        end

    // Write beat held until accepted
    a_wdf_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (app_wdf_wren && !app_wdf_rdy) |=> (app_wdf_wren && $stable(app_wdf_data)))
        else begin
            $error("write beat changed before app_wdf_rdy");
            fail_count++;
        end

    // End only on the high beat, right after the low beat or while it stalls
    a_wdf_end: assert property (@(posedge clk) disable iff (!rst_n)
        app_wdf_end |-> (app_wdf_wren
                         && ($past(app_wdf_end && !app_wdf_rdy)
                             || $past(app_wdf_wren && app_wdf_rdy && !app_wdf_end))))
        else begin
            $error("app_wdf_end outside the second write beat");
            fail_count++;
        end

    a_allow_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(write_allowed) && !$isunknown(read_allowed))
        else begin
            $error("allow flag unknown after reset");
            fail_count++;
        end

endmodule

bind ddr_memory_interface ddr_memory_interface_asserts u_asserts (.*);

/* testbench/tb_ddr_memory_interface.sv */
// ######################################
// Vector driven testbench with one op per line
// Runs from testbench/ddr_vectors.txt
// ######################################

`timescale 1ns/1ps

module tb_ddr_memory_interface;

    localparam int MAX_VEC = 64;
    localparam int TIMEOUT = 2000;  // Cycles allowed per wait

    logic                 clk;
    logic                 rst_n;
    ddr_if_pkg::addr_t    wr_adx_in;
    ddr_if_pkg::data_t    wr_data_in;
    logic                 write_req;
    logic                 write_allowed;
    logic                 writes_pending;
    ddr_if_pkg::addr_t    rd_adx_in;
    logic                 read_req;
    logic                 read_allowed;
    logic                 reads_pending;
    ddr_if_pkg::data_t    rd_data_return;
    ddr_if_pkg::addr_t    rd_adx_return;
    logic                 has_return_data;
    logic                 get_return_data;
    ddr_if_pkg::addr_t    app_addr;
    ddr_if_pkg::app_cmd_t app_cmd;
    logic                 app_en;
    logic                 app_rdy;
    ddr_if_pkg::beat_t    app_wdf_data;
    logic                 app_wdf_wren;
    logic                 app_wdf_end;
    logic                 app_wdf_rdy;
    ddr_if_pkg::beat_t    app_rd_data;
    logic                 app_rd_data_valid;
    logic                 app_rd_data_end;
    logic                 hold_off;         // Controller stall request

    ddr_if_pkg::data_t    vec_mem [0:4*MAX_VEC-1]; // Four fields per vector
    ddr_if_pkg::addr_t    exp_addr_q [$];          // Expected returns in issue order
    ddr_if_pkg::data_t    exp_data_q [$];
    int                   check_count;
    int                   error_count;
    int                   timeout_count;

    tb_clock_gen clk_gen (.clk(clk), .rst_n(rst_n));

    ddr_memory_interface dut0 (.*);

    app_mem_model ctrl_model (
        .clk, .rst_n, .hold_off,
        .app_addr, .app_cmd, .app_en, .app_rdy,
        .app_wdf_data, .app_wdf_wren, .app_wdf_end, .app_wdf_rdy,
        .app_rd_data, .app_rd_data_valid, .app_rd_data_end
    );

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 check_count, error_count, timeout_count, dut0.u_asserts.fail_count);
        if (error_count == 0 && timeout_count == 0 && dut0.u_asserts.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT at %0t: gave up waiting for %s", $time, what);
        timeout_count++;
        finish_run();
    endtask

    task automatic check_data(input string what, input ddr_if_pkg::data_t got,
                              input ddr_if_pkg::data_t exp);
        check_count++;
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(input string what, input ddr_if_pkg::addr_t got,
                              input ddr_if_pkg::addr_t exp);
        check_count++;
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    // All drive tasks start and end on a falling edge
    task automatic send_write(input ddr_if_pkg::addr_t a, input ddr_if_pkg::data_t d);
        int waited;
        waited = 0;
        while (!write_allowed) begin    // Hold off while the queue is full
            if (waited == TIMEOUT) report_timeout("write_allowed");
            @(negedge clk);
            waited++;
        end
        wr_adx_in  = a;
        wr_data_in = d;
        write_req  = 1'b1;
        @(negedge clk);
        write_req  = 1'b0;
    endtask

    task automatic send_read(input ddr_if_pkg::addr_t a, input ddr_if_pkg::data_t d);
        int waited;
        waited = 0;
        while (!read_allowed) begin     // Consumer drains to make room
            if (waited == TIMEOUT) report_timeout("read_allowed");
            if (has_return_data) begin
                take_return();
            end else begin
                @(negedge clk);
            end
            waited++;
        end
        rd_adx_in = a;
        read_req  = 1'b1;
        exp_addr_q.push_back(a);
        exp_data_q.push_back(d);
        @(negedge clk);
        read_req  = 1'b0;
    endtask

    task automatic wait_writes_done();
        int waited;
        waited = 0;
        while (writes_pending) begin
            if (waited == TIMEOUT) report_timeout("writes_pending to fall");
            @(negedge clk);
            waited++;
        end
    endtask

    // Pop one return and compare with the oldest issued read
    task automatic take_return();
        int waited;
        waited = 0;
        while (!has_return_data) begin
            if (waited == TIMEOUT) report_timeout("has_return_data");
            @(negedge clk);
            waited++;
        end
        check_addr("rd_adx_return", rd_adx_return, exp_addr_q.pop_front());
        check_data("rd_data_return", rd_data_return, exp_data_q.pop_front());
        get_return_data = 1'b1;
        @(negedge clk);
        get_return_data = 1'b0;
    endtask

    // n of 0 drains everything expected
    task automatic drain_returns(input int n);
        int left;
        left = (n == 0) ? exp_addr_q.size() : n;
        while (left > 0 && exp_addr_q.size() > 0) begin
            take_return();
            left--;
        end
    endtask

    task automatic settle_and_drain();
        int waited;
        waited = 0;
        while (writes_pending || reads_pending) begin
            if (waited == TIMEOUT) report_timeout("pending flags to clear");
            @(negedge clk);
            waited++;
        end
        drain_returns(0);
        @(negedge clk);
        check_flag("has_return_data after drain", has_return_data, 1'b0);
        check_flag("writes_pending at end", writes_pending, 1'b0);
        check_flag("reads_pending at end", reads_pending, 1'b0);
    endtask

    initial begin
        int                i;
        int                waited;
        logic [3:0]        op;
        logic              done;
        ddr_if_pkg::addr_t va;
        ddr_if_pkg::data_t vd;
        ddr_if_pkg::data_t ve;
        wr_adx_in       = '0;
        wr_data_in      = '0;
        write_req       = 1'b0;
        rd_adx_in       = '0;
        read_req        = 1'b0;
        get_return_data = 1'b0;
        hold_off        = 1'b0;
        check_count     = 0;
        error_count     = 0;
        timeout_count   = 0;
        $readmemh("testbench/ddr_vectors.txt", vec_mem);

        waited = 0;
        @(negedge clk);
        while (!rst_n) begin
            if (waited == TIMEOUT) report_timeout("reset release");
            @(negedge clk);
            waited++;
        end
        @(negedge clk);

        i    = 0;
        done = 1'b0;
        while (!done && i < MAX_VEC) begin
            op = vec_mem[4*i][3:0];
            va = ddr_if_pkg::addr_t'(vec_mem[4*i+1]);
            vd = vec_mem[4*i+2];
            ve = vec_mem[4*i+3];
            case (op)
                4'd0: done = 1'b1;
                4'd1: send_write(va, vd);
                4'd2: send_read(va, ve);
                4'd3: wait_writes_done();
                4'd4: drain_returns(int'(va));
                4'd5: begin                 // Flag select in address field
                    if (va == 0) check_flag("write_allowed", write_allowed, vd[0]);
                    else check_flag("read_allowed", read_allowed, vd[0]);
                end
                4'd6: hold_off = va[0];
                default: begin
                    $display("Vector %0d has an unknown operation code, run stopped", i);
                    error_count++;
                    done = 1'b1;
                end
            endcase
            i++;
        end

        settle_and_drain();
        finish_run();
    end

endmodule

/* ddr_memory_interface.f */
+incdir+include
design/ddr_if_pkg.sv
design/sync_fifo.sv
design/ddr_fifo.sv
design/fifo_to_app.sv
design/ddr_memory_interface.sv
testbench/tb_clock_gen.sv
testbench/app_mem_model.sv
testbench/ddr_memory_interface_asserts.sv
testbench/tb_ddr_memory_interface.sv

/* testbench/ddr_vectors.txt */
// op addr word expected_word, all hex
// op 1 write, 2 read, 3 wait writes, 4 drain n (0 all), 5 check flag, 6 stall, 0 end
1 0000100 0123456789abcdeffedcba9876543210 0
1 0000204 00112233445566778899aabbccddeeff 0
1 0000308 deadbeefcafef00d0badc0de12345678 0
1 000040c a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 0
3 0 0 0
2 0000308 0 deadbeefcafef00d0badc0de12345678
2 0000100 0 0123456789abcdeffedcba9876543210
2 000040c 0 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0
2 0000204 0 00112233445566778899aabbccddeeff
4 0 0 0
6 1 0 0
1 0001000 c00000000000000ad00000000000000a 0
1 0001001 c00000000000001ad00000000000001a 0
1 0001002 c00000000000002ad00000000000002a 0
1 0001003 c00000000000003ad00000000000003a 0
1 0001004 c00000000000004ad00000000000004a 0
1 0001005 c00000000000005ad00000000000005a 0
1 0001006 c00000000000006ad00000000000006a 0
1 0001007 c00000000000007ad00000000000007a 0
5 0 0 0
6 0 0 0
1 0001008 c00000000000008ad00000000000008a 0
3 0 0 0
2 0001000 0 c00000000000000ad00000000000000a
2 0001001 0 c00000000000001ad00000000000001a
2 0001002 0 c00000000000002ad00000000000002a
2 0001003 0 c00000000000003ad00000000000003a
2 0001004 0 c00000000000004ad00000000000004a
2 0001005 0 c00000000000005ad00000000000005a
2 0001006 0 c00000000000006ad00000000000006a
2 0001007 0 c00000000000007ad00000000000007a
5 1 0 0
4 1 0 0
5 1 1 0
2 0001008 0 c00000000000008ad00000000000008a
1 0002000 3c3c3c3c3c3c3c3c1234123412341234 0
2 0000100 0 0123456789abcdeffedcba9876543210
1 0002004 77778888999900001111222233334444 0
2 0000204 0 00112233445566778899aabbccddeeff
3 0 0 0
2 0002000 0 3c3c3c3c3c3c3c3c1234123412341234
2 0002004 0 77778888999900001111222233334444
0 0 0 0
